//--- flist.f
hw/soc_periph_pkg.sv
hw/apb_if.sv
hw/periph_bus_demux.sv
hw/timer_channel.sv
hw/gpio_lite.sv
hw/fc_event_map.sv
hw/soc_periph_top.sv
testbench/tb_soc_periph.sv

//--- hw/apb_if.sv
////////////////////
// APB slot bus between the demultiplexer and one peripheral
// No wait states, slaves tie pready high
////////////////////
`default_nettype none

interface apb_if import soc_periph_pkg::*; ();

    logic [APB_ADDR_WIDTH-1:0] paddr;
    logic [APB_DATA_WIDTH-1:0] pwdata;
    logic                      pwrite;
    logic                      psel;
    logic                      penable;
    logic [APB_DATA_WIDTH-1:0] prdata;
    logic                      pready;
    logic                      pslverr;

    // Demultiplexer side
    modport master (
        output paddr, pwdata, pwrite, psel, penable,
        input  prdata, pready, pslverr
    );

    // Peripheral side
    modport slave (
        input  paddr, pwdata, pwrite, psel, penable,
        output prdata, pready, pslverr
    );

endinterface

`default_nettype wire

//--- hw/fc_event_map.sv
////////////////////
// Fabric-controller event word, registered, one cycle behind its sources
// slow_clk_i is treated as asynchronous, both of its edges give a pulse
////////////////////
`default_nettype none

module fc_event_map import soc_periph_pkg::*; (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      slow_clk_i,
    input  logic [NB_TIMER_CH-1:0]    timer_evt_i,
    input  logic                      gpio_irq_i,
    input  logic                      dma_pe_evt_i,
    input  logic                      pf_evt_i,
    output logic [FC_EVENT_WIDTH-1:0] fc_events_o
);

    logic                      slow_meta_q;
    logic                      slow_sync_q;
    logic                      slow_prev_q;
    logic                      ref_edge;
    logic [FC_EVENT_WIDTH-1:0] evt_word;

    // Reference clock synchroniser and edge register
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            slow_meta_q <= 1'b0;
            slow_sync_q <= 1'b0;
            slow_prev_q <= 1'b0;
        end else begin
            slow_meta_q <= slow_clk_i;
            slow_sync_q <= slow_meta_q;
            slow_prev_q <= slow_sync_q;
        end
    end

    assign ref_edge = slow_sync_q ^ slow_prev_q;

    // Fixed placement, every other bit is zero
    always_comb begin
        evt_word              = '0;
        evt_word[EVT_DMA_PE]  = dma_pe_evt_i;
        evt_word[EVT_PF]      = pf_evt_i;
        evt_word[EVT_REF_CLK] = ref_edge;
        evt_word[EVT_GPIO]    = gpio_irq_i;
        for (int k = 0; k < NB_TIMER_CH; k++) begin
            evt_word[EVT_TIMER_BASE + k] = timer_evt_i[k];
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            fc_events_o <= '0;
        end else begin
            fc_events_o <= evt_word;
        end
    end

endmodule

`default_nettype wire

//--- hw/gpio_lite.sv
////////////////////
// GPIO with direction and output registers and a rising-edge interrupt
// gpio_i goes through a two-flop synchroniser, GPIO_IN reads its output
// Edges set status when enabled, writing one clears a status bit
////////////////////
`default_nettype none

module gpio_lite import soc_periph_pkg::*; (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic [NGPIO-1:0] gpio_i,
    apb_if.slave             bus,
    output logic [NGPIO-1:0] gpio_out_o,
    output logic [NGPIO-1:0] gpio_dir_o,
    output logic             irq_o
);

    logic [NGPIO-1:0]           dir_q;
    logic [NGPIO-1:0]           out_q;
    logic [NGPIO-1:0]           inten_q;
    logic [NGPIO-1:0]           status_q;
    logic [NGPIO-1:0]           in_meta_q;
    logic [NGPIO-1:0]           in_sync_q;
    logic [NGPIO-1:0]           in_prev_q;

    logic [REG_OFFSET_BITS-1:0] reg_offset;
    logic                       reg_write;
    logic [NGPIO-1:0]           rise;
    logic [NGPIO-1:0]           status_clr;

    assign reg_offset = bus.paddr[REG_OFFSET_LSB +: REG_OFFSET_BITS];
    assign reg_write  = bus.psel && bus.penable && bus.pwrite;

    ////////////////////
    // Input synchroniser and edge detect

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            in_meta_q <= '0;
            in_sync_q <= '0;
            in_prev_q <= '0;
        end else begin
            in_meta_q <= gpio_i;
            in_sync_q <= in_meta_q;
            in_prev_q <= in_sync_q;
        end
    end

    assign rise       = in_sync_q & ~in_prev_q;
    assign status_clr = (reg_write && (reg_offset == GPIO_INTSTATUS))
                        ? bus.pwdata[NGPIO-1:0] : '0;

    ////////////////////
    // Registers

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            dir_q    <= '0;
            out_q    <= '0;
            inten_q  <= '0;
            status_q <= '0;
        end else begin
            if (reg_write) begin
                case (reg_offset)
                    GPIO_DIR:   dir_q   <= bus.pwdata[NGPIO-1:0];
                    GPIO_OUT:   out_q   <= bus.pwdata[NGPIO-1:0];
                    GPIO_INTEN: inten_q <= bus.pwdata[NGPIO-1:0];
                    default: ;
                endcase
            end
            // A new edge wins over a clear in the same cycle
            status_q <= (status_q & ~status_clr) | (rise & inten_q);
        end
    end

    always_comb begin
        bus.prdata = '0;
        case (reg_offset)
            GPIO_DIR:       bus.prdata[NGPIO-1:0] = dir_q;
            GPIO_OUT:       bus.prdata[NGPIO-1:0] = out_q;
            GPIO_IN:        bus.prdata[NGPIO-1:0] = in_sync_q;
            GPIO_INTEN:     bus.prdata[NGPIO-1:0] = inten_q;
            GPIO_INTSTATUS: bus.prdata[NGPIO-1:0] = status_q;
            default: ;
        endcase
    end

    assign bus.pready  = 1'b1;
    assign bus.pslverr = 1'b0;

    assign gpio_out_o = out_q;
    assign gpio_dir_o = dir_q;
    assign irq_o      = |status_q;

endmodule

`default_nettype wire

//--- hw/periph_bus_demux.sv
////////////////////
// Slot decoder for the peripheral APB port, purely combinational
// Slots at or above NB_SLOTS answer with pslverr and zero read data
////////////////////
`default_nettype none

module periph_bus_demux import soc_periph_pkg::*; (
    input  logic [APB_ADDR_WIDTH-1:0] apb_paddr_i,
    input  logic [APB_DATA_WIDTH-1:0] apb_pwdata_i,
    input  logic                      apb_pwrite_i,
    input  logic                      apb_psel_i,
    input  logic                      apb_penable_i,
    output logic [APB_DATA_WIDTH-1:0] apb_prdata_o,
    output logic                      apb_pready_o,
    output logic                      apb_pslverr_o,
    apb_if.master                     slv_bus [NB_SLOTS]
);

    logic [SLOT_BITS-1:0]      slot_idx;
    logic [APB_DATA_WIDTH-1:0] slot_rdata [NB_SLOTS];
    logic [NB_SLOTS-1:0]       slot_ready;
    logic [NB_SLOTS-1:0]       slot_err;

    assign slot_idx = apb_paddr_i[SLOT_LSB +: SLOT_BITS];

    ////////////////////
    // Request fan-out

    for (genvar i = 0; i < NB_SLOTS; i++) begin : gen_slot
        // Address, data and direction go to every slot, only psel is decoded
        assign slv_bus[i].paddr   = apb_paddr_i;
        assign slv_bus[i].pwdata  = apb_pwdata_i;
        assign slv_bus[i].pwrite  = apb_pwrite_i;
        assign slv_bus[i].penable = apb_penable_i;
        assign slv_bus[i].psel    = apb_psel_i && (slot_idx == SLOT_BITS'(i));

        // Collect responses so they can be picked by a variable index
        assign slot_rdata[i] = slv_bus[i].prdata;
        assign slot_ready[i] = slv_bus[i].pready;
        assign slot_err[i]   = slv_bus[i].pslverr;
    end

    ////////////////////
    // Response return

    always_comb begin
        // Unmapped slot by default
        apb_prdata_o  = '0;
        apb_pready_o  = 1'b1;
        apb_pslverr_o = 1'b1;
        for (int i = 0; i < NB_SLOTS; i++) begin
            if (slot_idx == SLOT_BITS'(i)) begin
                apb_prdata_o  = slot_rdata[i];
                apb_pready_o  = slot_ready[i];
                apb_pslverr_o = slot_err[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/soc_periph_pkg.sv
////////////////////
// Address map, register offsets and event positions of the peripheral subsystem
// Slot field is paddr[11:8], register offset is paddr[4:2]
// Timers count on clk_i, no slow-clock prescaler
////////////////////
`default_nettype none

package soc_periph_pkg;

    ////////////////////
    // APB bus and slot map
    localparam int unsigned APB_ADDR_WIDTH  = 32;
    localparam int unsigned APB_DATA_WIDTH  = 32;
    localparam int unsigned SLOT_LSB        = 8;
    localparam int unsigned SLOT_BITS       = 4;
    // Timer channels in slots 0 to 3, GPIO in slot 4
    localparam int unsigned NB_SLOTS        = 5;
    localparam int unsigned GPIO_SLOT       = 4;
    localparam int unsigned REG_OFFSET_LSB  = 2;
    localparam int unsigned REG_OFFSET_BITS = 3;

    ////////////////////
    // Peripheral sizes
    localparam int unsigned NB_TIMER_CH     = 4;
    localparam int unsigned TIMER_WIDTH     = 16;
    localparam int unsigned NGPIO           = 8;

    // Timer registers
    localparam logic [REG_OFFSET_BITS-1:0] TMR_CTRL      = 3'd0;
    localparam logic [REG_OFFSET_BITS-1:0] TMR_THRESHOLD = 3'd1;
    localparam logic [REG_OFFSET_BITS-1:0] TMR_COMPARE   = 3'd2;
    localparam logic [REG_OFFSET_BITS-1:0] TMR_COUNTER   = 3'd3;
    localparam int unsigned TMR_CTRL_EN_BIT  = 0;
    localparam int unsigned TMR_CTRL_CLR_BIT = 1;

    // GPIO registers, INTSTATUS is write one to clear
    localparam logic [REG_OFFSET_BITS-1:0] GPIO_DIR       = 3'd0;
    localparam logic [REG_OFFSET_BITS-1:0] GPIO_OUT       = 3'd1;
    localparam logic [REG_OFFSET_BITS-1:0] GPIO_IN        = 3'd2;
    localparam logic [REG_OFFSET_BITS-1:0] GPIO_INTEN     = 3'd3;
    localparam logic [REG_OFFSET_BITS-1:0] GPIO_INTSTATUS = 3'd4;

    ////////////////////
    // Fabric-controller event word
    localparam int unsigned FC_EVENT_WIDTH = 32;
    localparam int unsigned EVT_DMA_PE     = 8;
    localparam int unsigned EVT_PF         = 12;
    localparam int unsigned EVT_REF_CLK    = 14;
    localparam int unsigned EVT_GPIO       = 15;
    // Timer channel k sits at EVT_TIMER_BASE + k
    localparam int unsigned EVT_TIMER_BASE = 17;

endpackage

`default_nettype wire

//--- hw/soc_periph_top.sv
////////////////////
// Peripheral subsystem top: APB slot demux, four timer channels, GPIO
// and the fabric-controller event word
////////////////////
`default_nettype none

module soc_periph_top import soc_periph_pkg::*; (
    input  logic                      clk_i,
    input  logic                      reset_i,

    // APB port from the core
    input  logic [APB_ADDR_WIDTH-1:0] apb_paddr_i,
    input  logic [APB_DATA_WIDTH-1:0] apb_pwdata_i,
    input  logic                      apb_pwrite_i,
    input  logic                      apb_psel_i,
    input  logic                      apb_penable_i,
    output logic [APB_DATA_WIDTH-1:0] apb_prdata_o,
    output logic                      apb_pready_o,
    output logic                      apb_pslverr_o,

    input  logic                      slow_clk_i,
    input  logic                      dma_pe_evt_i,
    input  logic                      pf_evt_i,

    input  logic [NGPIO-1:0]          gpio_i,
    output logic [NGPIO-1:0]          gpio_out_o,
    output logic [NGPIO-1:0]          gpio_dir_o,

    output logic [NB_TIMER_CH-1:0]    timer_ch_o,
    output logic [FC_EVENT_WIDTH-1:0] fc_events_o
);

    apb_if slot_bus [NB_SLOTS] ();

    logic [NB_TIMER_CH-1:0] timer_evt;
    logic                   gpio_irq;

    ////////////////////
    // Peripheral bus

    periph_bus_demux u_bus_demux (
        .apb_paddr_i   ( apb_paddr_i   ),
        .apb_pwdata_i  ( apb_pwdata_i  ),
        .apb_pwrite_i  ( apb_pwrite_i  ),
        .apb_psel_i    ( apb_psel_i    ),
        .apb_penable_i ( apb_penable_i ),
        .apb_prdata_o  ( apb_prdata_o  ),
        .apb_pready_o  ( apb_pready_o  ),
        .apb_pslverr_o ( apb_pslverr_o ),
        .slv_bus       ( slot_bus      )
    );

    ////////////////////
    // Timer channels, channel k in slot k

    for (genvar k = 0; k < NB_TIMER_CH; k++) begin : gen_timer
        timer_channel u_timer (
            .clk_i   ( clk_i         ),
            .reset_i ( reset_i       ),
            .bus     ( slot_bus[k]   ),
            .evt_o   ( timer_evt[k]  ),
            .pwm_o   ( timer_ch_o[k] )
        );
    end

    ////////////////////
    // GPIO and events

    gpio_lite u_gpio (
        .clk_i      ( clk_i               ),
        .reset_i    ( reset_i             ),
        .gpio_i     ( gpio_i              ),
        .bus        ( slot_bus[GPIO_SLOT] ),
        .gpio_out_o ( gpio_out_o          ),
        .gpio_dir_o ( gpio_dir_o          ),
        .irq_o      ( gpio_irq            )
    );

    fc_event_map u_event_map (
        .clk_i        ( clk_i        ),
        .reset_i      ( reset_i      ),
        .slow_clk_i   ( slow_clk_i   ),
        .timer_evt_i  ( timer_evt    ),
        .gpio_irq_i   ( gpio_irq     ),
        .dma_pe_evt_i ( dma_pe_evt_i ),
        .pf_evt_i     ( pf_evt_i     ),
        .fc_events_o  ( fc_events_o  )
    );

endmodule

`default_nettype wire

//--- hw/timer_channel.sv
////////////////////
// One timer channel: free-running counter with threshold wrap and PWM compare
// evt_o is combinational, high on the cycle where counter equals threshold
// Lowering the threshold below the counter makes it wrap on the next cycle
////////////////////
`default_nettype none

module timer_channel import soc_periph_pkg::*; (
    input  logic clk_i,
    input  logic reset_i,
    apb_if.slave bus,
    output logic evt_o,
    output logic pwm_o
);

    logic                       enable_q;
    logic [TIMER_WIDTH-1:0]     threshold_q;
    logic [TIMER_WIDTH-1:0]     compare_q;
    logic [TIMER_WIDTH-1:0]     counter_q;

    logic [REG_OFFSET_BITS-1:0] reg_offset;
    logic                       reg_write;
    logic                       clear_req;
    logic                       at_threshold;

    assign reg_offset = bus.paddr[REG_OFFSET_LSB +: REG_OFFSET_BITS];

    // Writes land on the edge that closes the access phase
    assign reg_write  = bus.psel && bus.penable && bus.pwrite;
    assign clear_req  = reg_write && (reg_offset == TMR_CTRL)
                        && bus.pwdata[TMR_CTRL_CLR_BIT];

    assign at_threshold = (counter_q == threshold_q);

    ////////////////////
    // Configuration registers

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            enable_q    <= 1'b0;
            threshold_q <= '0;
            compare_q   <= '0;
        end else if (reg_write) begin
            case (reg_offset)
                TMR_CTRL:      enable_q    <= bus.pwdata[TMR_CTRL_EN_BIT];
                TMR_THRESHOLD: threshold_q <= bus.pwdata[TIMER_WIDTH-1:0];
                TMR_COMPARE:   compare_q   <= bus.pwdata[TIMER_WIDTH-1:0];
                default: ;
            endcase
        end
    end

    ////////////////////
    // Counter

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            counter_q <= '0;
        end else if (clear_req) begin
            counter_q <= '0;
        end else if (enable_q) begin
            // Period is threshold+1 cycles
            if (counter_q >= threshold_q) begin
                counter_q <= '0;
            end else begin
                counter_q <= counter_q + 1'b1;
            end
        end
    end

    ////////////////////
    // Read-back

    always_comb begin
        bus.prdata = '0;
        case (reg_offset)
            TMR_CTRL:      bus.prdata[TMR_CTRL_EN_BIT]   = enable_q;
            TMR_THRESHOLD: bus.prdata[TIMER_WIDTH-1:0]   = threshold_q;
            TMR_COMPARE:   bus.prdata[TIMER_WIDTH-1:0]   = compare_q;
            TMR_COUNTER:   bus.prdata[TIMER_WIDTH-1:0]   = counter_q;
            default: ;
        endcase
    end

    assign bus.pready  = 1'b1;
    assign bus.pslverr = 1'b0;

    // Both outputs stay low while the channel is stopped
    assign evt_o = enable_q && at_threshold;
    assign pwm_o = enable_q && (counter_q < compare_q);

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the peripheral subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module tb_soc_periph \
    -Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TESTS PASSED" "$LOG"; then
    exit 0
fi
exit 1

//--- testbench/tb_soc_periph.sv
////////////////////
// Directed testbench for soc_periph_top
// Inputs change 1 time unit after the rising edge, outputs are sampled on the falling edge
// Every task returns 1 time unit after a rising edge
////////////////////
`default_nettype none

module tb_soc_periph import soc_periph_pkg::*; ();

    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 5;
    // Cycle budget per test: registers, period, duty, GPIO, events
    localparam int TEST_CYCLES   = 60 + 140 + 130 + 70 + 70;
    localparam int WATCHDOG_TIME = (RESET_CYCLES + TEST_CYCLES + 100) * CLK_PERIOD;

    localparam logic [31:0] USED_EVENTS = (32'd1 << EVT_DMA_PE) | (32'd1 << EVT_PF)
        | (32'd1 << EVT_REF_CLK) | (32'd1 << EVT_GPIO)
        | (((32'd1 << NB_TIMER_CH) - 32'd1) << EVT_TIMER_BASE);

    logic                   clk = 1'b0;
    logic                   rst;
    logic [31:0]            apb_paddr;
    logic [31:0]            apb_pwdata;
    logic                   apb_pwrite;
    logic                   apb_psel;
    logic                   apb_penable;
    logic [31:0]            apb_prdata;
    logic                   apb_pready;
    logic                   apb_pslverr;
    logic                   slow_clk;
    logic                   dma_pe_evt;
    logic                   pf_evt;
    logic [NGPIO-1:0]       gpio_pins;
    logic [NGPIO-1:0]       gpio_out;
    logic [NGPIO-1:0]       gpio_dir;
    logic [NB_TIMER_CH-1:0] timer_ch;
    logic [31:0]            fc_events;

    int                     errors = 0;
    logic [15:0]            lfsr_q = 16'd7;

    soc_periph_top dut0 (
        .clk_i         ( clk         ),
        .reset_i       ( rst         ),
        .apb_paddr_i   ( apb_paddr   ),
        .apb_pwdata_i  ( apb_pwdata  ),
        .apb_pwrite_i  ( apb_pwrite  ),
        .apb_psel_i    ( apb_psel    ),
        .apb_penable_i ( apb_penable ),
        .apb_prdata_o  ( apb_prdata  ),
        .apb_pready_o  ( apb_pready  ),
        .apb_pslverr_o ( apb_pslverr ),
        .slow_clk_i    ( slow_clk    ),
        .dma_pe_evt_i  ( dma_pe_evt  ),
        .pf_evt_i      ( pf_evt      ),
        .gpio_i        ( gpio_pins   ),
        .gpio_out_o    ( gpio_out    ),
        .gpio_dir_o    ( gpio_dir    ),
        .timer_ch_o    ( timer_ch    ),
        .fc_events_o   ( fc_events   )
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////
    // Helpers

    function automatic logic [31:0] slot_addr(input int slot,
                                              input logic [REG_OFFSET_BITS-1:0] offset);
        return (32'(slot) << SLOT_LSB) | (32'(offset) << REG_OFFSET_LSB);
    endfunction

    function automatic logic [15:0] threshold_of(input int k);
        return 16'(5 + 3 * k);
    endfunction

    // Compare 0 and a compare above the period are both covered
    function automatic logic [15:0] compare_of(input int k);
        case (k)
            0:       return 16'd3;
            1:       return 16'd0;
            2:       return 16'd20;
            default: return 16'd6;
        endcase
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(output logic [NGPIO-1:0] bits);
        for (int i = 0; i < NGPIO; i++) begin
            bits[i] = lfsr_q[0];
            lfsr_q  = lfsr_next(lfsr_q);
        end
    endtask

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    // Setup cycle, then access cycle with data sampled before the closing edge
    task automatic apb_transfer(input logic wr, input logic [31:0] addr,
                                input logic [31:0] wdata,
                                output logic [31:0] rdata, output logic err);
        apb_paddr   = addr;
        apb_pwdata  = wdata;
        apb_pwrite  = wr;
        apb_psel    = 1'b1;
        apb_penable = 1'b0;
        @(posedge clk);
        #1;
        apb_penable = 1'b1;
        @(negedge clk);
        assert (apb_pready === 1'b1) else begin
            errors++;
            $display("APB slave did not raise pready in the access cycle");
        end
        rdata = apb_prdata;
        err   = apb_pslverr;
        @(posedge clk);
        #1;
        apb_psel    = 1'b0;
        apb_penable = 1'b0;
        apb_pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        apb_transfer(1'b1, addr, data, rdata, err);
        expect_equal("apb_pslverr_o", 32'(err), 32'd0);
    endtask

    task automatic read_check(input string name, input logic [31:0] addr,
                              input logic [31:0] exp);
        logic [31:0] rdata;
        logic        err;
        apb_transfer(1'b0, addr, 32'd0, rdata, err);
        expect_equal(name, rdata, exp);
        expect_equal("apb_pslverr_o", 32'(err), 32'd0);
    endtask

    ////////////////////
    // Tests

    task automatic register_readback();
        logic [31:0] rdata;
        logic        err;
        logic [15:0] thr;
        logic [15:0] cmp;
        for (int k = 0; k < NB_TIMER_CH; k++) begin
            thr = 16'hA5A0 ^ 16'(k);
            cmp = 16'h5A0F ^ 16'(k << 4);
            apb_write(slot_addr(k, TMR_THRESHOLD), 32'(thr));
            apb_write(slot_addr(k, TMR_COMPARE), 32'(cmp));
            read_check("TMR_THRESHOLD", slot_addr(k, TMR_THRESHOLD), 32'(thr));
            read_check("TMR_COMPARE", slot_addr(k, TMR_COMPARE), 32'(cmp));
        end
        apb_write(slot_addr(GPIO_SLOT, GPIO_DIR), 32'h3C);
        apb_write(slot_addr(GPIO_SLOT, GPIO_OUT), 32'hC3);
        read_check("GPIO_DIR", slot_addr(GPIO_SLOT, GPIO_DIR), 32'h3C);
        read_check("GPIO_OUT", slot_addr(GPIO_SLOT, GPIO_OUT), 32'hC3);
        expect_equal("gpio_dir_o", 32'(gpio_dir), 32'h3C);
        expect_equal("gpio_out_o", 32'(gpio_out), 32'hC3);
        // Slot 7 is unmapped
        apb_transfer(1'b0, slot_addr(7, '0), 32'd0, rdata, err);
        expect_equal("apb_pslverr_o", 32'(err), 32'd1);
        expect_equal("apb_prdata_o", rdata, 32'd0);
    endtask

    task automatic timer_period();
        int   last_pulse [NB_TIMER_CH];
        int   pulses [NB_TIMER_CH];
        logic prev_hi [NB_TIMER_CH];
        logic hit;
        for (int k = 0; k < NB_TIMER_CH; k++) begin
            apb_write(slot_addr(k, TMR_THRESHOLD), 32'(threshold_of(k)));
            apb_write(slot_addr(k, TMR_COMPARE), 32'(compare_of(k)));
            apb_write(slot_addr(k, TMR_CTRL), 32'h1);
            last_pulse[k] = 0;
            pulses[k]     = 0;
            prev_hi[k]    = 1'b0;
        end
        for (int cyc = 0; cyc < 100; cyc++) begin
            @(negedge clk);
            for (int k = 0; k < NB_TIMER_CH; k++) begin
                hit = fc_events[EVT_TIMER_BASE + k];
                if (hit) begin
                    assert (!prev_hi[k]) else begin
                        errors++;
                        $display("Timer channel %0d event lasted more than one cycle", k);
                    end
                    if (pulses[k] > 0) begin
                        expect_equal("fc_events_o timer gap", 32'(cyc - last_pulse[k]),
                                     32'(threshold_of(k)) + 32'd1);
                    end
                    last_pulse[k] = cyc;
                    pulses[k]++;
                end
                prev_hi[k] = hit;
            end
        end
        for (int k = 0; k < NB_TIMER_CH; k++) begin
            assert (pulses[k] >= 3) else begin
                errors++;
                $display("Timer channel %0d gave fewer than three events", k);
            end
        end
        @(posedge clk);
        #1;
    endtask

    task automatic pwm_duty();
        int          high_cycles;
        int          waited;
        logic [31:0] period;
        logic [31:0] rdata;
        logic        err;
        logic        found;
        for (int k = 0; k < NB_TIMER_CH; k++) begin
            high_cycles = 0;
            period      = 32'(threshold_of(k)) + 32'd1;
            for (int c = 0; c < int'(period); c++) begin
                @(negedge clk);
                if (timer_ch[k]) begin
                    high_cycles++;
                end
            end
            expect_equal("timer_ch_o high cycles", 32'(high_cycles),
                         (32'(compare_of(k)) < period) ? 32'(compare_of(k)) : period);
            @(posedge clk);
            #1;
        end
        // Align to the wrap of channel 0, so without the clear the read would see the threshold
        waited = 0;
        while (!fc_events[EVT_TIMER_BASE] && waited < int'(threshold_of(0)) + 2) begin
            @(negedge clk);
            waited++;
        end
        assert (fc_events[EVT_TIMER_BASE]) else begin
            errors++;
            $display("Timer channel 0 gave no event before the clear write");
        end
        repeat (2) @(posedge clk);
        #1;
        // Clear channel 0 and keep it enabled
        apb_write(slot_addr(0, TMR_CTRL), 32'h3);
        apb_transfer(1'b0, slot_addr(0, TMR_COUNTER), 32'd0, rdata, err);
        assert (rdata < 32'(threshold_of(0))) else begin
            errors++;
            $display("[FAIL] TMR_COUNTER got 0x%h expected below 0x%h", rdata, threshold_of(0));
        end
        read_check("TMR_CTRL", slot_addr(0, TMR_CTRL), 32'h1);
        found = 1'b0;
        for (int c = 0; c < 2 * int'(threshold_of(0)) + 2; c++) begin
            @(negedge clk);
            found = found | fc_events[EVT_TIMER_BASE];
        end
        assert (found) else begin
            errors++;
            $display("Timer channel 0 stopped after the clear write");
        end
        @(posedge clk);
        #1;
    endtask

    task automatic gpio_input_irq();
        logic [NGPIO-1:0] pattern;
        logic [NGPIO-1:0] inten;
        logic [NGPIO-1:0] expected;
        take_bits(pattern);
        gpio_pins = pattern;
        @(posedge clk);
        #1;
        read_check("GPIO_IN", slot_addr(GPIO_SLOT, GPIO_IN), 32'(pattern));
        gpio_pins = '0;
        repeat (4) @(posedge clk);
        #1;
        // Rises so far had no enable bit
        read_check("GPIO_INTSTATUS", slot_addr(GPIO_SLOT, GPIO_INTSTATUS), 32'd0);
        take_bits(pattern);
        pattern[0]       = 1'b1;
        pattern[NGPIO-1] = 1'b1;
        inten            = NGPIO'(32'h0F);
        expected         = pattern & inten;
        apb_write(slot_addr(GPIO_SLOT, GPIO_INTEN), 32'(inten));
        gpio_pins = pattern;
        repeat (5) @(posedge clk);
        #1;
        read_check("GPIO_INTSTATUS", slot_addr(GPIO_SLOT, GPIO_INTSTATUS), 32'(expected));
        @(negedge clk);
        expect_equal("fc_events_o[15]", 32'(fc_events[EVT_GPIO]), 32'd1);
        @(posedge clk);
        #1;
        apb_write(slot_addr(GPIO_SLOT, GPIO_INTSTATUS), 32'(expected));
        read_check("GPIO_INTSTATUS", slot_addr(GPIO_SLOT, GPIO_INTSTATUS), 32'd0);
        @(negedge clk);
        expect_equal("fc_events_o[15]", 32'(fc_events[EVT_GPIO]), 32'd0);
        @(posedge clk);
        #1;
        gpio_pins = '0;
    endtask

    task automatic event_passthrough();
        int   ref_pulses;
        logic prev_ref;
        ref_pulses = 0;
        prev_ref   = 1'b0;
        for (int i = 0; i < 6; i++) begin
            slow_clk = ~slow_clk;
            for (int c = 0; c < 5; c++) begin
                @(negedge clk);
                if (fc_events[EVT_REF_CLK]) begin
                    assert (!prev_ref) else begin
                        errors++;
                        $display("Reference clock event lasted more than one cycle");
                    end
                    ref_pulses++;
                end
                prev_ref = fc_events[EVT_REF_CLK];
            end
            @(posedge clk);
            #1;
        end
        expect_equal("fc_events_o[14] pulse count", 32'(ref_pulses), 32'd6);
        // Pass-through bits lag their inputs by one cycle
        dma_pe_evt = 1'b1;
        @(negedge clk);
        expect_equal("fc_events_o[8]", 32'(fc_events[EVT_DMA_PE]), 32'd0);
        @(posedge clk);
        #1;
        dma_pe_evt = 1'b0;
        pf_evt     = 1'b1;
        @(negedge clk);
        expect_equal("fc_events_o[8]", 32'(fc_events[EVT_DMA_PE]), 32'd1);
        expect_equal("fc_events_o[12]", 32'(fc_events[EVT_PF]), 32'd0);
        @(posedge clk);
        #1;
        pf_evt = 1'b0;
        @(negedge clk);
        expect_equal("fc_events_o[8]", 32'(fc_events[EVT_DMA_PE]), 32'd0);
        expect_equal("fc_events_o[12]", 32'(fc_events[EVT_PF]), 32'd1);
        @(posedge clk);
        #1;
    endtask

    ////////////////////
    // Unused event bits, checked on every cycle

    always @(negedge clk) begin
        if (!rst) begin
            assert ((fc_events & ~USED_EVENTS) == 32'd0) else begin
                errors++;
                $display("[FAIL] fc_events_o unused bits got 0x%h expected 0x0",
                         fc_events & ~USED_EVENTS);
            end
        end
    end

    initial begin
        rst         = 1'b1;
        apb_paddr   = '0;
        apb_pwdata  = '0;
        apb_pwrite  = 1'b0;
        apb_psel    = 1'b0;
        apb_penable = 1'b0;
        slow_clk    = 1'b0;
        dma_pe_evt  = 1'b0;
        pf_evt      = 1'b0;
        gpio_pins   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        expect_equal("fc_events_o", fc_events, 32'd0);
        expect_equal("timer_ch_o", 32'(timer_ch), 32'd0);
        expect_equal("gpio_out_o", 32'(gpio_out), 32'd0);
        expect_equal("gpio_dir_o", 32'(gpio_dir), 32'd0);
        @(posedge clk);
        #1;
        register_readback();
        timer_period();
        pwm_duty();
        gpio_input_irq();
        event_passthrough();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Watchdog expired before the tests finished");
        $display("Errors: %0d", errors);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
